// ==== rtl/ecc_pkg.sv ====
package ecc_pkg;

    localparam int DATA_WIDTH   = 109;
    localparam int PARITY_WIDTH = 8;
    localparam int COUNT_WIDTH  = 16;

    // register offsets on the APB side.
    localparam logic [7:0] ADDR_DATA0     = 8'h00;
    localparam logic [7:0] ADDR_DATA1     = 8'h04;
    localparam logic [7:0] ADDR_DATA2     = 8'h08;
    localparam logic [7:0] ADDR_DATA3     = 8'h0C;
    localparam logic [7:0] ADDR_PARITY    = 8'h10;
    localparam logic [7:0] ADDR_CTRL      = 8'h14;
    localparam logic [7:0] ADDR_STATUS    = 8'h18;
    localparam logic [7:0] ADDR_RESULT0   = 8'h1C;
    localparam logic [7:0] ADDR_RESULT1   = 8'h20;
    localparam logic [7:0] ADDR_RESULT2   = 8'h24;
    localparam logic [7:0] ADDR_RESULT3   = 8'h28;
    localparam logic [7:0] ADDR_SBE_COUNT = 8'h2C;
    localparam logic [7:0] ADDR_DBE_COUNT = 8'h30;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]   data;
        logic [PARITY_WIDTH-1:0] parity; // check bits as received.
        logic                    bypass;
    } ecc_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]   data;
        logic [PARITY_WIDTH-1:0] parity; // check bits computed from the data.
        logic                    sbit_err;
        logic                    dbit_err;
    } ecc_result_t;

    // codeword position of data bit idx, skipping the powers of two from 3 upwards.
    function automatic int unsigned ecc_position(int unsigned idx);
        int unsigned pos;
        int unsigned n;
        pos = 3;
        n = 0;
        while (n < idx) begin
            pos++;
            if ((pos & (pos - 1)) != 0) n++;
        end
        return pos;
    endfunction

    // H-matrix column of data bit idx. The top check bit makes every column odd weight.
    function automatic int unsigned ecc_column(int unsigned idx, int unsigned pw);
        int unsigned pos;
        int unsigned col;
        pos = ecc_position(idx);
        col = pos & ((32'd1 << (pw - 1)) - 1);
        if (($countones(pos) % 2) == 0) col = col | (32'd1 << (pw - 1));
        return col;
    endfunction

endpackage

// ==== rtl/ecc_encoder.sv ====
`timescale 1ns/1ps

module ecc_encoder
    import ecc_pkg::*;
#(
    parameter int DATA_WIDTH   = ecc_pkg::DATA_WIDTH,
    parameter int PARITY_WIDTH = ecc_pkg::PARITY_WIDTH
) (
    input  logic [DATA_WIDTH-1:0]   data,
    output logic [PARITY_WIDTH-1:0] parity
);

    // selects the data bits that feed check bit k.
    function automatic logic [DATA_WIDTH-1:0] check_mask(int unsigned k);
        logic [DATA_WIDTH-1:0] m;
        int unsigned col;
        m = '0;
        for (int unsigned i = 0; i < DATA_WIDTH; i++) begin
            col = ecc_column(i, PARITY_WIDTH);
            m[i] = ((col >> k) & 32'd1) != 0;
        end
        return m;
    endfunction

    // the last data bit must land below the position range of the check bits.
    if (ecc_position(DATA_WIDTH - 1) >= (32'd1 << (PARITY_WIDTH - 1))) begin : g_fit_check
        $error("ecc_encoder: %0d data bits do not fit %0d check bits",
               DATA_WIDTH, PARITY_WIDTH);
    end

    for (genvar k = 0; k < PARITY_WIDTH; k++) begin : g_check
        localparam logic [DATA_WIDTH-1:0] MASK = check_mask(k);
        assign parity[k] = ^(data & MASK);
    end

endmodule

// ==== rtl/ecc_corrector.sv ====
`timescale 1ns/1ps

module ecc_corrector
    import ecc_pkg::*;
#(
    parameter int DATA_WIDTH   = ecc_pkg::DATA_WIDTH,
    parameter int PARITY_WIDTH = ecc_pkg::PARITY_WIDTH
) (
    input  ecc_req_t                req,
    input  logic [PARITY_WIDTH-1:0] calc_parity,
    output ecc_result_t             result
);

    logic [PARITY_WIDTH-1:0] syndrome;
    logic [DATA_WIDTH-1:0]   flip;       // one-hot when the syndrome names a data bit.
    logic                    data_hit;
    logic                    check_hit;

    assign syndrome = req.parity ^ calc_parity;

    // each data bit compares the syndrome against its own column.
    for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_col
        localparam logic [PARITY_WIDTH-1:0] COL = PARITY_WIDTH'(ecc_column(i, PARITY_WIDTH));
        assign flip[i] = (syndrome == COL);
    end

    assign data_hit  = |flip;
    assign check_hit = $onehot(syndrome); // a lone check bit flipped in storage.

    always_comb begin
        result.data     = req.data;
        result.parity   = calc_parity;
        result.sbit_err = 1'b0;
        result.dbit_err = 1'b0;
        if (!req.bypass && (syndrome != '0)) begin
            if (data_hit) begin
                result.data     = req.data ^ flip;
                result.sbit_err = 1'b1;
            end else if (check_hit) begin
                result.sbit_err = 1'b1;
            end else begin
                // even weight or an unused column, so it cannot be a single error.
                result.dbit_err = 1'b1;
            end
        end
    end

    always_comb begin
        a_flags_exclusive: assert (!(result.sbit_err && result.dbit_err))
            else $error("ecc_corrector: single and double error flagged together");
    end

endmodule

// ==== rtl/ecc_err_counter.sv ====
`timescale 1ns/1ps

module ecc_err_counter
    import ecc_pkg::*;
#(
    parameter int COUNT_WIDTH = ecc_pkg::COUNT_WIDTH
) (
    input  logic                   pclk,
    input  logic                   rst_n,
    input  logic                   sbe_inc,
    input  logic                   dbe_inc,
    input  logic                   sbe_clr,
    input  logic                   dbe_clr,
    output logic [COUNT_WIDTH-1:0] sbe_count,
    output logic [COUNT_WIDTH-1:0] dbe_count
);

    logic [COUNT_WIDTH-1:0] cnt [2]; // entry 0 counts corrected, entry 1 uncorrectable.
    logic [1:0]             inc;
    logic [1:0]             clr;

    assign inc = {dbe_inc, sbe_inc};
    assign clr = {dbe_clr, sbe_clr};

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt[0] <= '0;
            cnt[1] <= '0;
        end else begin
            for (int n = 0; n < 2; n++) begin
                if (clr[n]) begin
                    cnt[n] <= '0;
                end else if (inc[n] && (cnt[n] != '1)) begin
                    cnt[n] <= cnt[n] + 1'b1;
                end
            end
        end
    end

    assign sbe_count = cnt[0];
    assign dbe_count = cnt[1];

    for (genvar n = 0; n < 2; n++) begin : g_sat
        a_no_wrap: assert property (@(posedge pclk) disable iff (!rst_n)
            (cnt[n] == '1) && !clr[n] |=> (cnt[n] != '0))
            else $error("ecc_err_counter: counter %0d wrapped", n);
    end

endmodule

// ==== rtl/ecc_ctrl_fsm.sv ====
`timescale 1ns/1ps

module ecc_ctrl_fsm
    import ecc_pkg::*;
(
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        go,
    input  ecc_req_t    req_in,
    input  ecc_result_t result_in,
    output ecc_req_t    req_out,
    output ecc_result_t result,
    output logic        busy,
    output logic        sbe_inc,
    output logic        dbe_inc
);

    typedef enum logic {
        IDLE,
        CALC
    } state_t;

    state_t state;

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (go) state <= CALC;
                CALC: state <= IDLE; // the datapath is combinational, one cycle suffices.
                default: state <= IDLE;
            endcase
        end
    end

    assign busy = (state == CALC);

    // the request is frozen for the encoder and corrector while CALC runs.
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            req_out <= '0;
        end else if ((state == IDLE) && go) begin
            req_out <= req_in;
        end
    end

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            result  <= '0;
            sbe_inc <= 1'b0;
            dbe_inc <= 1'b0;
        end else begin
            sbe_inc <= busy && result_in.sbit_err;
            dbe_inc <= busy && result_in.dbit_err;
            if (busy) result <= result_in;
        end
    end

    a_busy_single: assert property (@(posedge pclk) disable iff (!rst_n) busy |=> !busy)
        else $error("ecc_ctrl_fsm: busy held for two cycles");

endmodule

// ==== rtl/ecc_apb_regs.sv ====
`timescale 1ns/1ps

module ecc_apb_regs
    import ecc_pkg::*;
(
    input  logic                   pclk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    input  ecc_result_t            result,
    input  logic                   busy,
    input  logic [COUNT_WIDTH-1:0] sbe_count,
    input  logic [COUNT_WIDTH-1:0] dbe_count,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output ecc_req_t               req,
    output logic                   go,
    output logic                   sbe_clr,
    output logic                   dbe_clr
);

    logic                    access;
    logic                    wr_en;
    logic                    mapped;
    logic [31:0]             rdata;
    logic [DATA_WIDTH-1:0]   data_q;
    logic [PARITY_WIDTH-1:0] parity_q;
    logic                    bypass_q;

    // 32-bit slice n of a data word, zero above the top bit.
    function automatic logic [31:0] read_word(logic [DATA_WIDTH-1:0] v, int unsigned n);
        logic [127:0] wide;
        wide = 128'(v);
        return wide[n*32 +: 32];
    endfunction

    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign pready = 1'b1;

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            data_q   <= '0;
            parity_q <= '0;
            bypass_q <= 1'b0;
            go       <= 1'b0;
            sbe_clr  <= 1'b0;
            dbe_clr  <= 1'b0;
        end else begin
            go      <= wr_en && (paddr == ADDR_CTRL) && pwdata[0];
            sbe_clr <= wr_en && (paddr == ADDR_SBE_COUNT); // any write data clears.
            dbe_clr <= wr_en && (paddr == ADDR_DBE_COUNT);
            if (wr_en) begin
                case (paddr)
                    ADDR_DATA0:  data_q[31:0]  <= pwdata;
                    ADDR_DATA1:  data_q[63:32] <= pwdata;
                    ADDR_DATA2:  data_q[95:64] <= pwdata;
                    ADDR_DATA3:  data_q[DATA_WIDTH-1:96] <= pwdata[DATA_WIDTH-97:0];
                    ADDR_PARITY: parity_q <= pwdata[PARITY_WIDTH-1:0];
                    ADDR_CTRL:   bypass_q <= pwdata[1];
                    default: ;
                endcase
            end
        end
    end

    assign req = '{data: data_q, parity: parity_q, bypass: bypass_q};

    always_comb begin
        rdata  = '0;
        mapped = 1'b1;
        case (paddr)
            ADDR_DATA0:   rdata = read_word(data_q, 0);
            ADDR_DATA1:   rdata = read_word(data_q, 1);
            ADDR_DATA2:   rdata = read_word(data_q, 2);
            ADDR_DATA3:   rdata = read_word(data_q, 3);
            ADDR_PARITY:  rdata = 32'(parity_q);
            ADDR_CTRL:    rdata = {30'd0, bypass_q, 1'b0}; // go is a strobe and reads as zero.
            ADDR_STATUS: begin
                rdata[0]    = busy;
                rdata[1]    = result.sbit_err;
                rdata[2]    = result.dbit_err;
                rdata[15:8] = result.parity;
            end
            ADDR_RESULT0:   rdata = read_word(result.data, 0);
            ADDR_RESULT1:   rdata = read_word(result.data, 1);
            ADDR_RESULT2:   rdata = read_word(result.data, 2);
            ADDR_RESULT3:   rdata = read_word(result.data, 3);
            ADDR_SBE_COUNT: rdata = 32'(sbe_count);
            ADDR_DBE_COUNT: rdata = 32'(dbe_count);
            default:        mapped = 1'b0;
        endcase
    end

    assign prdata  = rdata;
    assign pslverr = access && !mapped;

    a_slverr_access: assert property (@(posedge pclk) disable iff (!rst_n)
        pslverr |-> psel && penable)
        else $error("ecc_apb_regs: pslverr outside an access phase");

endmodule

// ==== rtl/ecc_apb_top.sv ====
`timescale 1ns/1ps

module ecc_apb_top
    import ecc_pkg::*;
#(
    parameter int DATA_WIDTH   = ecc_pkg::DATA_WIDTH,
    parameter int PARITY_WIDTH = ecc_pkg::PARITY_WIDTH,
    parameter int COUNT_WIDTH  = ecc_pkg::COUNT_WIDTH
) (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    ecc_req_t                req_regs;
    ecc_req_t                req_calc;
    ecc_result_t             result_comb;
    ecc_result_t             result_q;
    logic [PARITY_WIDTH-1:0] calc_parity;
    logic [COUNT_WIDTH-1:0]  sbe_count;
    logic [COUNT_WIDTH-1:0]  dbe_count;
    logic                    go;
    logic                    busy;
    logic                    sbe_inc;
    logic                    dbe_inc;
    logic                    sbe_clr;
    logic                    dbe_clr;

    // the structs and the register map are sized by the package widths.
    if ((DATA_WIDTH != ecc_pkg::DATA_WIDTH) || (PARITY_WIDTH != ecc_pkg::PARITY_WIDTH) ||
        (COUNT_WIDTH != ecc_pkg::COUNT_WIDTH)) begin : g_width_check
        $error("ecc_apb_top: parameters differ from the package widths");
    end

    ecc_apb_regs u_regs (
        .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .result    (result_q),
        .busy, .sbe_count, .dbe_count,
        .prdata, .pready, .pslverr,
        .req       (req_regs),
        .go, .sbe_clr, .dbe_clr
    );

    ecc_ctrl_fsm u_fsm (
        .pclk, .rst_n, .go,
        .req_in    (req_regs),
        .result_in (result_comb),
        .req_out   (req_calc),
        .result    (result_q),
        .busy, .sbe_inc, .dbe_inc
    );

    ecc_encoder #(.DATA_WIDTH(DATA_WIDTH), .PARITY_WIDTH(PARITY_WIDTH)) u_encoder (
        .data      (req_calc.data),
        .parity    (calc_parity)
    );

    ecc_corrector #(.DATA_WIDTH(DATA_WIDTH), .PARITY_WIDTH(PARITY_WIDTH)) u_corrector (
        .req         (req_calc),
        .calc_parity (calc_parity),
        .result      (result_comb)
    );

    ecc_err_counter #(.COUNT_WIDTH(COUNT_WIDTH)) u_counter (
        .pclk, .rst_n, .sbe_inc, .dbe_inc, .sbe_clr, .dbe_clr, .sbe_count, .dbe_count
    );

endmodule

// ==== verif/ecc_tb.sv ====
`timescale 1ns/1ps

module ecc_tb
    import ecc_pkg::*;
();

    localparam int CLK_PERIOD         = 4;
    localparam int ACCESSES_PER_CHECK = 19;
    localparam int NUM_CHECKS         = 5;
    localparam int NUM_REG_ACCESSES   = 6;
    localparam int NUM_ACCESSES       = ACCESSES_PER_CHECK * NUM_CHECKS + NUM_REG_ACCESSES;
    localparam int WATCHDOG_NS        = 200 * NUM_ACCESSES * CLK_PERIOD;

    logic        pclk = 1'b0;
    logic        rst_n = 1'b0;
    logic        psel = 1'b0;
    logic        penable = 1'b0;
    logic        pwrite = 1'b0;
    logic [7:0]  paddr = 8'h00;
    logic [31:0] pwdata = 32'h0;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] exp_rdata = 32'h0;
    logic        exp_slverr = 1'b0;
    logic        chk_rd = 1'b0;   // compare prdata in this access.
    string       reg_name = "";
    int          errors = 0;
    int          sbe_model = 0;
    int          dbe_model = 0;
    integer      seed = 32'hc3729182;

    ecc_apb_top dut (
        .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    always #(CLK_PERIOD / 2) pclk = ~pclk;

    // extended Hamming check bits, data bit i at the i-th non power of two from 3.
    function automatic logic [PARITY_WIDTH-1:0] model_parity(logic [DATA_WIDTH-1:0] d);
        logic [PARITY_WIDTH-1:0] p;
        int unsigned pos;
        p = '0;
        pos = 3;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            for (int k = 0; k < PARITY_WIDTH - 1; k++) begin
                if (pos[k]) p[k] = p[k] ^ d[i];
            end
            if (($countones(pos) % 2) == 0) p[PARITY_WIDTH-1] = p[PARITY_WIDTH-1] ^ d[i];
            pos++;
            if ((pos & (pos - 1)) == 0) pos++; // skip the check-bit slots.
        end
        return p;
    endfunction

    function automatic logic [31:0] word_of(logic [DATA_WIDTH-1:0] v, int n);
        logic [127:0] wide;
        wide = {{(128 - DATA_WIDTH){1'b0}}, v};
        return wide[n*32 +: 32];
    endfunction

    function automatic logic [DATA_WIDTH-1:0] random_word();
        logic [127:0] r;
        r = {$random(seed), $random(seed), $random(seed), $random(seed)};
        return r[DATA_WIDTH-1:0];
    endfunction

    function automatic int random_index(int limit);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % limit);
    endfunction

    task automatic apb_access(input string name, input logic [7:0] addr, input logic write,
                              input logic [31:0] wdata, input logic [31:0] exp,
                              input logic check, input logic exp_err);
        @(posedge pclk);
        psel       <= 1'b1;
        penable    <= 1'b0;
        pwrite     <= write;
        paddr      <= addr;
        pwdata     <= wdata;
        reg_name   <= name;
        exp_rdata  <= exp;
        chk_rd     <= check && !write;
        exp_slverr <= exp_err;
        @(posedge pclk);
        penable <= 1'b1;
        @(posedge pclk);
        while (!pready) @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
        chk_rd  <= 1'b0;
    endtask

    task automatic write_reg(input string name, input logic [7:0] addr, input logic [31:0] wdata);
        apb_access(name, addr, 1'b1, wdata, 32'h0, 1'b0, 1'b0);
    endtask

    task automatic read_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
        apb_access(name, addr, 1'b0, 32'h0, exp, 1'b1, 1'b0);
    endtask

    // loads one request, starts it and reads back every register it touches.
    task automatic run_check(input logic [DATA_WIDTH-1:0] wr_data,
                             input logic [PARITY_WIDTH-1:0] wr_parity, input logic bypass,
                             input logic [DATA_WIDTH-1:0] exp_data, input logic exp_sbit,
                             input logic exp_dbit, input logic [PARITY_WIDTH-1:0] exp_parity);
        logic [31:0] status;
        status = {16'd0, exp_parity, 5'd0, exp_dbit, exp_sbit, 1'b0};
        for (int n = 0; n < 4; n++) begin
            write_reg($sformatf("DATA%0d", n), 8'(ADDR_DATA0 + 4 * n), word_of(wr_data, n));
        end
        write_reg("PARITY", ADDR_PARITY, 32'(wr_parity));
        for (int n = 0; n < 4; n++) begin
            read_reg($sformatf("DATA%0d", n), 8'(ADDR_DATA0 + 4 * n), word_of(wr_data, n));
        end
        read_reg("PARITY", ADDR_PARITY, 32'(wr_parity));
        write_reg("CTRL", ADDR_CTRL, {30'd0, bypass, 1'b1});
        read_reg("STATUS", ADDR_STATUS, status);
        read_reg("CTRL", ADDR_CTRL, {30'd0, bypass, 1'b0});
        for (int n = 0; n < 4; n++) begin
            read_reg($sformatf("RESULT%0d", n), 8'(ADDR_RESULT0 + 4 * n), word_of(exp_data, n));
        end
        if (exp_sbit) sbe_model++;
        if (exp_dbit) dbe_model++;
        read_reg("SBE_COUNT", ADDR_SBE_COUNT, 32'(sbe_model));
        read_reg("DBE_COUNT", ADDR_DBE_COUNT, 32'(dbe_model));
    endtask

    a_read_data: assert property (@(posedge pclk) disable iff (!rst_n)
        (psel && penable && !pwrite && chk_rd) |-> (prdata == exp_rdata))
        else begin
            errors++;
            $display("ERROR %s: expected 0x%08h actual 0x%08h",
                     reg_name, $sampled(exp_rdata), $sampled(prdata));
        end

    a_slverr: assert property (@(posedge pclk) disable iff (!rst_n)
        (psel && penable) |-> (pslverr == exp_slverr))
        else begin
            errors++;
            $display("ERROR pslverr at %s: expected 0x%0h actual 0x%0h",
                     reg_name, $sampled(exp_slverr), $sampled(pslverr));
        end

    a_ready: assert property (@(posedge pclk) disable iff (!rst_n)
        (psel && penable) |-> pready)
        else begin
            errors++;
            $display("ERROR pready at %s: expected 0x1 actual 0x%0h",
                     reg_name, $sampled(pready));
        end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [DATA_WIDTH-1:0]   d;
        logic [DATA_WIDTH-1:0]   dc;
        logic [PARITY_WIDTH-1:0] p;
        logic [PARITY_WIDTH-1:0] pc;
        int                      b1;
        int                      b2;

        repeat (16) @(posedge pclk);
        rst_n <= 1'b1;

        d = random_word(); // clean word.
        p = model_parity(d);
        run_check(d, p, 1'b0, d, 1'b0, 1'b0, p);

        d  = random_word();
        p  = model_parity(d);
        dc = d;
        b1 = random_index(DATA_WIDTH);
        dc[b1] = ~dc[b1];
        run_check(dc, p, 1'b0, d, 1'b1, 1'b0, model_parity(dc));

        d  = random_word(); // a stored check bit goes bad.
        p  = model_parity(d);
        pc = p;
        b1 = random_index(PARITY_WIDTH);
        pc[b1] = ~pc[b1];
        run_check(d, pc, 1'b0, d, 1'b1, 1'b0, p);

        d  = random_word();
        p  = model_parity(d);
        b1 = random_index(DATA_WIDTH);
        b2 = random_index(DATA_WIDTH);
        while (b2 == b1) b2 = random_index(DATA_WIDTH);
        dc = d;
        dc[b1] = ~dc[b1];
        dc[b2] = ~dc[b2];
        run_check(dc, p, 1'b0, dc, 1'b0, 1'b1, model_parity(dc));

        d  = random_word(); // bypass leaves the flip in place and counts nothing.
        p  = model_parity(d);
        dc = d;
        b1 = random_index(DATA_WIDTH);
        dc[b1] = ~dc[b1];
        run_check(dc, p, 1'b1, dc, 1'b0, 1'b0, model_parity(dc));

        apb_access("unmapped read", 8'h34, 1'b0, 32'h0, 32'h0, 1'b0, 1'b1);
        apb_access("unmapped write", 8'hFC, 1'b1, 32'hFFFF_FFFF, 32'h0, 1'b0, 1'b1);
        write_reg("SBE_COUNT", ADDR_SBE_COUNT, 32'h0000_1234);
        sbe_model = 0;
        read_reg("SBE_COUNT", ADDR_SBE_COUNT, 32'(sbe_model));
        write_reg("DBE_COUNT", ADDR_DBE_COUNT, 32'h0);
        dbe_model = 0;
        read_reg("DBE_COUNT", ADDR_DBE_COUNT, 32'(dbe_model));

        repeat (4) @(posedge pclk);
        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/ecc_pkg.sv
rtl/ecc_encoder.sv
rtl/ecc_corrector.sv
rtl/ecc_err_counter.sv
rtl/ecc_ctrl_fsm.sv
rtl/ecc_apb_regs.sv
rtl/ecc_apb_top.sv
verif/ecc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides pass or fail from the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module ecc_tb -Mdir "$OBJ" -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vecc_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi
